//--- design/ohci_desc_pkg.sv
/* shared widths, descriptor field positions and types of the OHCI descriptor unpacker
   every design file refers to these by scoped name */
`default_nettype none

package ohci_desc_pkg;

    localparam int unsigned dword_w    = 32;                // dma data word
    localparam int unsigned addr_lsb   = 4;                 // descriptors are 16-byte aligned
    localparam int unsigned addr_w     = dword_w - addr_lsb;
    localparam int unsigned desc_words = 4;                 // words per ED or TD

    // word counter in the fetch tracker, counts 0..desc_words
    localparam int unsigned desc_cnt_w = $clog2(desc_words) + 1;
    localparam logic [desc_cnt_w-1:0] desc_full = desc_cnt_w'(desc_words);

    // ED word 0 flags
    localparam int unsigned ed_skip_bit = 14;
    // ED word 2 holds HeadP, halt in bit 0 and toggle carry in bit 1
    localparam int unsigned headp_halt_bit = 0;
    // address fields: ED w1 TailP, ED w2 HeadP, ED w3 NextED, TD w2 NextTD
    // all of them in bits dword_w-1:addr_lsb

    localparam int unsigned cbsr_w   = 2;
    localparam int unsigned cb_cnt_w = cbsr_w + 1;          // room for cbsr plus one

    typedef logic [dword_w-1:0] dword_t;
    typedef logic [addr_w-1:0]  addr_t;                     // address bits 31:4
    typedef logic [cbsr_w-1:0]  cbsr_t;

    typedef enum logic [2:0] {
        idle,
        pick_list,   // choose control or bulk
        fetch_ed,    // ED request out
        wait_ed,
        fetch_td,    // decide pass-over or TD request
        wait_td,
        write_back,  // new HeadP to the ED
        finish
    } walk_state_e;

endpackage

`default_nettype wire

//--- design/ohci_fetch_tracker.sv
/* input side of the descriptor unpacker, gathers the four DMA words of the
   outstanding fetch into one descriptor and drains words that nobody asked for */
`timescale 1ns/10ps
`default_nettype none

module ohci_fetch_tracker (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  fetch_done_i,  // fetch handshake on the request port
    input  ohci_desc_pkg::dword_t dma_data_i,
    input  logic                  dma_valid_i,
    output logic                  dma_ready_o,
    output logic                  desc_valid_o,  // one cycle, words below valid
    output ohci_desc_pkg::dword_t desc_w0_o,
    output ohci_desc_pkg::dword_t desc_w1_o,
    output ohci_desc_pkg::dword_t desc_w2_o,
    output ohci_desc_pkg::dword_t desc_w3_o
);

    logic                                 outstanding_q; // a fetch waits for its words
    logic [ohci_desc_pkg::desc_cnt_w-1:0] cnt_q;         // words collected
    ohci_desc_pkg::dword_t                words_q [ohci_desc_pkg::desc_words];
    logic                                 full;
    logic                                 word_hs;
    logic                                 word_take;

    assign full = (cnt_q == ohci_desc_pkg::desc_full);

    // only the hand-over cycle holds the bus off
    // with nothing outstanding ready stays up and words drain
    assign dma_ready_o  = !outstanding_q || !full;
    assign word_hs      = dma_valid_i && dma_ready_o;
    assign word_take    = word_hs && outstanding_q; // stray words fall through here
    assign desc_valid_o = outstanding_q && full;    // cycle after the fourth word

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            outstanding_q <= 1'b0;
            cnt_q         <= '0;
        end else if (desc_valid_o) begin
            outstanding_q <= 1'b0; // handed over, back to flushing
            cnt_q         <= '0;
        end else if (fetch_done_i) begin
            outstanding_q <= 1'b1; // window opens
            cnt_q         <= '0;
        end else if (word_take) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // word store, in arrival order
    always_ff @(posedge clk_i) begin
        if (word_take) begin
            words_q[cnt_q[ohci_desc_pkg::desc_cnt_w-2:0]] <= dma_data_i;
        end
    end

    assign desc_w0_o = words_q[0]; // ED flags or TD control
    assign desc_w1_o = words_q[1]; // TailP or current buffer
    assign desc_w2_o = words_q[2]; // HeadP or NextTD
    assign desc_w3_o = words_q[3]; // NextED or buffer end

endmodule

`default_nettype wire

//--- design/ohci_cb_ratio_counter.sv
/* control/bulk service ratio, counts served control TDs since the last bulk TD
   and flags when cbsr_i plus one of them have gone by */
`timescale 1ns/10ps
`default_nettype none

module ohci_cb_ratio_counter (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  ohci_desc_pkg::cbsr_t cbsr_i,           // ratio minus one
    input  logic                 served_control_i,
    input  logic                 served_bulk_i,
    input  logic                 clear_i,          // start of a walk
    output logic                 ratio_reached_o   // bulk's turn
);

    logic [ohci_desc_pkg::cb_cnt_w-1:0] count_q; // control TDs in this round

    assign ratio_reached_o = (count_q > {1'b0, cbsr_i});

    always_ff @(posedge clk_i) begin
        if (rst_i || clear_i || served_bulk_i) begin
            count_q <= '0; // new round
        end else if (served_control_i && !ratio_reached_o) begin
            count_q <= count_q + 1'b1; // saturates at cbsr plus one
        end
    end

endmodule

`default_nettype wire

//--- design/ohci_list_walker.sv
/* list processing FSM, walks the control and bulk ED lists one TD per ED visit
   and decides every descriptor fetch and ED writeback */
`timescale 1ns/10ps
`default_nettype none

module ohci_list_walker (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  start_i,        // walk both lists from their heads
    input  ohci_desc_pkg::cbsr_t  cbsr_i,
    input  ohci_desc_pkg::addr_t  control_head_i,
    input  ohci_desc_pkg::addr_t  bulk_head_i,
    input  logic                  desc_valid_i,
    input  ohci_desc_pkg::dword_t desc_w0_i,
    input  ohci_desc_pkg::dword_t desc_w1_i,
    input  ohci_desc_pkg::dword_t desc_w2_i,
    input  ohci_desc_pkg::dword_t desc_w3_i,
    input  logic                  fetch_done_i,
    input  logic                  wb_done_i,
    output logic                  issue_o,        // one cycle fetch request
    output ohci_desc_pkg::addr_t  issue_addr_o,
    output logic                  issue_is_td_o,
    output logic                  wb_issue_o,     // one cycle writeback request
    output ohci_desc_pkg::addr_t  wb_addr_o,
    output ohci_desc_pkg::dword_t wb_headp_o,
    output logic                  done_o,
    output logic                  busy_o
);

    ohci_desc_pkg::walk_state_e state_q;

    // per list position
    ohci_desc_pkg::addr_t  ctrl_ed_q;
    ohci_desc_pkg::addr_t  bulk_ed_q;
    logic                  ctrl_end_q;    // NextED of zero reached
    logic                  bulk_end_q;
    logic                  cur_bulk_q;    // list of the ED in service

    // ED in service
    ohci_desc_pkg::addr_t  ed_addr_q;
    logic                  ed_skip_q;
    ohci_desc_pkg::addr_t  ed_tailp_q;
    ohci_desc_pkg::dword_t ed_headp_q;    // whole word 2, flags in the low bits
    ohci_desc_pkg::addr_t  ed_next_q;
    ohci_desc_pkg::addr_t  td_next_q;     // NextTD of the served TD

    logic                  fetch_seen_q;  // request handshake done
    logic                  wb_sent_q;     // writeback handed to the port

    ohci_desc_pkg::addr_t  headp_addr;
    logic                  ratio_reached;
    logic                  pick_bulk;
    logic                  pass_over;
    logic                  desc_take;
    logic                  served;
    logic                  advance;
    logic                  clear;

    assign headp_addr = ed_headp_q[ohci_desc_pkg::dword_w-1:ohci_desc_pkg::addr_lsb];
    // skipped, halted or empty EDs get no TD fetch
    assign pass_over  = ed_skip_q || ed_headp_q[ohci_desc_pkg::headp_halt_bit]
                        || (headp_addr == ed_tailp_q);
    assign pick_bulk  = !bulk_end_q && (ratio_reached || ctrl_end_q);
    assign desc_take  = desc_valid_i && fetch_seen_q;
    assign served     = (state_q == ohci_desc_pkg::write_back) && wb_done_i;
    assign advance    = served || ((state_q == ohci_desc_pkg::fetch_td) && pass_over);
    assign clear      = (state_q == ohci_desc_pkg::idle) && start_i;

    assign issue_o       = (state_q == ohci_desc_pkg::fetch_ed)
                           || ((state_q == ohci_desc_pkg::fetch_td) && !pass_over);
    assign issue_is_td_o = (state_q == ohci_desc_pkg::fetch_td);
    assign issue_addr_o  = issue_is_td_o ? headp_addr : ed_addr_q;
    assign wb_issue_o    = (state_q == ohci_desc_pkg::write_back) && !wb_sent_q;
    assign wb_addr_o     = ed_addr_q;
    // new HeadP, halt and toggle carry carried over
    assign wb_headp_o    = {td_next_q, ed_headp_q[ohci_desc_pkg::addr_lsb-1:0]};
    assign done_o        = (state_q == ohci_desc_pkg::finish);
    assign busy_o        = (state_q != ohci_desc_pkg::idle);

    ohci_cb_ratio_counter ohci_cb_ratio_counter_i (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .cbsr_i           (cbsr_i),
        .served_control_i (served && !cur_bulk_q),
        .served_bulk_i    (served && cur_bulk_q),
        .clear_i          (clear),
        .ratio_reached_o  (ratio_reached)
    );

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q      <= ohci_desc_pkg::idle;
            ctrl_end_q   <= 1'b1;
            bulk_end_q   <= 1'b1;
            cur_bulk_q   <= 1'b0;
            fetch_seen_q <= 1'b0;
            wb_sent_q    <= 1'b0;
        end else begin
            if (issue_o) begin
                fetch_seen_q <= 1'b0;
            end else if (fetch_done_i) begin
                fetch_seen_q <= 1'b1;
            end
            if (wb_issue_o) begin
                wb_sent_q <= 1'b1;
            end else if (wb_done_i) begin
                wb_sent_q <= 1'b0;
            end
            if (advance) begin // a zero NextED ends the list
                if (cur_bulk_q) begin
                    bulk_end_q <= (ed_next_q == '0);
                end else begin
                    ctrl_end_q <= (ed_next_q == '0);
                end
            end
            case (state_q)
                ohci_desc_pkg::idle: begin
                    if (start_i) begin
                        ctrl_end_q <= (control_head_i == '0); // empty list
                        bulk_end_q <= (bulk_head_i == '0);
                        state_q    <= ohci_desc_pkg::pick_list;
                    end
                end
                ohci_desc_pkg::pick_list: begin
                    if (ctrl_end_q && bulk_end_q) begin
                        state_q <= ohci_desc_pkg::finish;
                    end else begin
                        cur_bulk_q <= pick_bulk;
                        state_q    <= ohci_desc_pkg::fetch_ed;
                    end
                end
                ohci_desc_pkg::fetch_ed: state_q <= ohci_desc_pkg::wait_ed;
                ohci_desc_pkg::wait_ed: begin
                    if (desc_take) begin
                        state_q <= ohci_desc_pkg::fetch_td;
                    end
                end
                ohci_desc_pkg::fetch_td: begin
                    state_q <= pass_over ? ohci_desc_pkg::pick_list : ohci_desc_pkg::wait_td;
                end
                ohci_desc_pkg::wait_td: begin
                    if (desc_take) begin
                        state_q <= ohci_desc_pkg::write_back;
                    end
                end
                ohci_desc_pkg::write_back: begin
                    if (wb_done_i) begin
                        state_q <= ohci_desc_pkg::pick_list; // TD served
                    end
                end
                ohci_desc_pkg::finish: state_q <= ohci_desc_pkg::idle;
                default: state_q <= ohci_desc_pkg::idle;
            endcase
        end
    end

    // pointers and unpacked fields
    always_ff @(posedge clk_i) begin
        if (clear) begin
            ctrl_ed_q <= control_head_i;
            bulk_ed_q <= bulk_head_i;
        end
        if (advance) begin
            if (cur_bulk_q) begin
                bulk_ed_q <= ed_next_q;
            end else begin
                ctrl_ed_q <= ed_next_q;
            end
        end
        if (state_q == ohci_desc_pkg::pick_list) begin
            ed_addr_q <= pick_bulk ? bulk_ed_q : ctrl_ed_q;
        end
        if ((state_q == ohci_desc_pkg::wait_ed) && desc_take) begin
            ed_skip_q  <= desc_w0_i[ohci_desc_pkg::ed_skip_bit];
            ed_tailp_q <= desc_w1_i[ohci_desc_pkg::dword_w-1:ohci_desc_pkg::addr_lsb];
            ed_headp_q <= desc_w2_i;
            ed_next_q  <= desc_w3_i[ohci_desc_pkg::dword_w-1:ohci_desc_pkg::addr_lsb];
        end
        if ((state_q == ohci_desc_pkg::wait_td) && desc_take) begin
            td_next_q <= desc_w2_i[ohci_desc_pkg::dword_w-1:ohci_desc_pkg::addr_lsb];
        end
    end

endmodule

`default_nettype wire

//--- design/ohci_request_port.sv
/* output side, holds the fetch request and the ED writeback until the DMA takes them
   and reports each completed handshake back to the walker */
`timescale 1ns/10ps
`default_nettype none

module ohci_request_port (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  issue_i,        // load fetch request
    input  ohci_desc_pkg::addr_t  issue_addr_i,
    input  logic                  issue_is_td_i,
    input  logic                  wb_issue_i,     // load writeback
    input  ohci_desc_pkg::addr_t  wb_addr_i,
    input  ohci_desc_pkg::dword_t wb_headp_i,
    output logic                  fetch_valid_o,
    output ohci_desc_pkg::addr_t  fetch_addr_o,
    output logic                  fetch_is_td_o,  // 0 ED, 1 TD
    input  logic                  fetch_ready_i,
    output logic                  fetch_done_o,   // handshake this cycle
    output logic                  wb_valid_o,
    output ohci_desc_pkg::addr_t  wb_addr_o,
    output ohci_desc_pkg::dword_t wb_headp_o,     // new ED word 2
    input  logic                  wb_ready_i,
    output logic                  wb_done_o
);

    assign fetch_done_o = fetch_valid_o && fetch_ready_i;
    assign wb_done_o    = wb_valid_o && wb_ready_i;

    // valid flags, set one cycle after issue and held until taken
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            fetch_valid_o <= 1'b0;
            wb_valid_o    <= 1'b0;
        end else begin
            if (issue_i) begin
                fetch_valid_o <= 1'b1;
            end else if (fetch_done_o) begin
                fetch_valid_o <= 1'b0;
            end
            if (wb_issue_i) begin
                wb_valid_o <= 1'b1;
            end else if (wb_done_o) begin
                wb_valid_o <= 1'b0;
            end
        end
    end

    // payload loads only on issue, so it stays put under back-pressure
    always_ff @(posedge clk_i) begin
        if (issue_i) begin
            fetch_addr_o  <= issue_addr_i;
            fetch_is_td_o <= issue_is_td_i;
        end
        if (wb_issue_i) begin
            wb_addr_o  <= wb_addr_i;
            wb_headp_o <= wb_headp_i;
        end
    end

endmodule

`default_nettype wire

//--- design/ohci_desc_unpacker_top.sv
/* descriptor unpacker of the OHCI control/bulk list processor
   DMA words in through the tracker, walker decides, request port drives the DMA */
`timescale 1ns/10ps
`default_nettype none

module ohci_desc_unpacker_top (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  start_i,
    input  ohci_desc_pkg::cbsr_t  cbsr_i,
    input  ohci_desc_pkg::addr_t  control_head_i,  // HcControlHeadED bits 31:4
    input  ohci_desc_pkg::addr_t  bulk_head_i,     // HcBulkHeadED bits 31:4
    input  ohci_desc_pkg::dword_t dma_data_i,
    input  logic                  dma_valid_i,
    output logic                  dma_ready_o,
    output logic                  fetch_valid_o,
    output ohci_desc_pkg::addr_t  fetch_addr_o,
    output logic                  fetch_is_td_o,
    input  logic                  fetch_ready_i,
    output logic                  wb_valid_o,
    output ohci_desc_pkg::addr_t  wb_addr_o,
    output ohci_desc_pkg::dword_t wb_headp_o,
    input  logic                  wb_ready_i,
    output logic                  done_o,          // one cycle at walk end
    output logic                  busy_o
);

    logic                  fetch_done;
    logic                  wb_done;
    logic                  desc_valid;
    ohci_desc_pkg::dword_t desc_w0;
    ohci_desc_pkg::dword_t desc_w1;
    ohci_desc_pkg::dword_t desc_w2;
    ohci_desc_pkg::dword_t desc_w3;
    logic                  issue;
    ohci_desc_pkg::addr_t  issue_addr;
    logic                  issue_is_td;
    logic                  wb_issue;
    ohci_desc_pkg::addr_t  wb_issue_addr;
    ohci_desc_pkg::dword_t wb_issue_headp;

    ohci_fetch_tracker ohci_fetch_tracker_i (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .fetch_done_i (fetch_done),
        .dma_data_i   (dma_data_i),
        .dma_valid_i  (dma_valid_i),
        .dma_ready_o  (dma_ready_o),
        .desc_valid_o (desc_valid),
        .desc_w0_o    (desc_w0),
        .desc_w1_o    (desc_w1),
        .desc_w2_o    (desc_w2),
        .desc_w3_o    (desc_w3)
    );

    ohci_list_walker ohci_list_walker_i (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .start_i        (start_i),
        .cbsr_i         (cbsr_i),
        .control_head_i (control_head_i),
        .bulk_head_i    (bulk_head_i),
        .desc_valid_i   (desc_valid),
        .desc_w0_i      (desc_w0),
        .desc_w1_i      (desc_w1),
        .desc_w2_i      (desc_w2),
        .desc_w3_i      (desc_w3),
        .fetch_done_i   (fetch_done),
        .wb_done_i      (wb_done),
        .issue_o        (issue),
        .issue_addr_o   (issue_addr),
        .issue_is_td_o  (issue_is_td),
        .wb_issue_o     (wb_issue),
        .wb_addr_o      (wb_issue_addr),
        .wb_headp_o     (wb_issue_headp),
        .done_o         (done_o),
        .busy_o         (busy_o)
    );

    ohci_request_port ohci_request_port_i (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .issue_i       (issue),
        .issue_addr_i  (issue_addr),
        .issue_is_td_i (issue_is_td),
        .wb_issue_i    (wb_issue),
        .wb_addr_i     (wb_issue_addr),
        .wb_headp_i    (wb_issue_headp),
        .fetch_valid_o (fetch_valid_o),
        .fetch_addr_o  (fetch_addr_o),
        .fetch_is_td_o (fetch_is_td_o),
        .fetch_ready_i (fetch_ready_i),
        .fetch_done_o  (fetch_done),
        .wb_valid_o    (wb_valid_o),
        .wb_addr_o     (wb_addr_o),
        .wb_headp_o    (wb_headp_o),
        .wb_ready_i    (wb_ready_i),
        .wb_done_o     (wb_done)
    );

endmodule

`default_nettype wire

//--- verification/ohci_desc_unpacker_sva.sv
/* handshake rules on the top-level outputs of the descriptor unpacker, bound to the top */
`timescale 1ns/10ps
`default_nettype none

module ohci_desc_unpacker_sva (
    input logic                  clk_i,
    input logic                  rst_i,
    input logic                  fetch_valid_i,
    input ohci_desc_pkg::addr_t  fetch_addr_i,
    input logic                  fetch_is_td_i,
    input logic                  fetch_ready_i,
    input logic                  wb_valid_i,
    input ohci_desc_pkg::addr_t  wb_addr_i,
    input ohci_desc_pkg::dword_t wb_headp_i,
    input logic                  wb_ready_i,
    input logic                  done_i
);

    // stalled fetch request holds still
    assert property (@(posedge clk_i) disable iff (rst_i)
        fetch_valid_i && !fetch_ready_i |=> fetch_valid_i && $stable(fetch_addr_i)
                                            && $stable(fetch_is_td_i))
        else $error("fetch request changed while stalled");

    assert property (@(posedge clk_i) disable iff (rst_i)
        wb_valid_i && !wb_ready_i |=> wb_valid_i && $stable(wb_addr_i) && $stable(wb_headp_i))
        else $error("writeback changed while stalled");

    assert property (@(posedge clk_i) disable iff (rst_i) done_i |=> !done_i)
        else $error("done pulse longer than one cycle");

    // valids cleared by reset
    assert property (@(posedge clk_i) rst_i |=> !fetch_valid_i && !wb_valid_i)
        else $error("request valid high during reset");

endmodule

bind ohci_desc_unpacker_top ohci_desc_unpacker_sva ohci_desc_unpacker_sva_i (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .fetch_valid_i (fetch_valid_o),
    .fetch_addr_i  (fetch_addr_o),
    .fetch_is_td_i (fetch_is_td_o),
    .fetch_ready_i (fetch_ready_i),
    .wb_valid_i    (wb_valid_o),
    .wb_addr_i     (wb_addr_o),
    .wb_headp_i    (wb_headp_o),
    .wb_ready_i    (wb_ready_i),
    .done_i        (done_o)
);

`default_nettype wire

//--- verification/tb_ohci_desc_unpacker.sv
/* directed testbench of the OHCI descriptor unpacker, a descriptor memory model answers
   each fetch with four words and every walk's fetches and writebacks are checked in order */
`timescale 1ns/10ps
`default_nettype none

module tb_ohci_desc_unpacker;

    logic                  clk_i;
    logic                  rst_i;
    logic                  start_i;
    ohci_desc_pkg::cbsr_t  cbsr_i;
    ohci_desc_pkg::addr_t  control_head_i;
    ohci_desc_pkg::addr_t  bulk_head_i;
    ohci_desc_pkg::dword_t dma_data_i;
    logic                  dma_valid_i;
    logic                  dma_ready_o;
    logic                  fetch_valid_o;
    ohci_desc_pkg::addr_t  fetch_addr_o;
    logic                  fetch_is_td_o;
    logic                  fetch_ready_i;
    logic                  wb_valid_o;
    ohci_desc_pkg::addr_t  wb_addr_o;
    ohci_desc_pkg::dword_t wb_headp_o;
    logic                  wb_ready_i;
    logic                  done_o;
    logic                  busy_o;

    ohci_desc_pkg::dword_t mem [logic [29:0]];   // key is {descriptor address, word}
    ohci_desc_pkg::dword_t dma_q [$];            // words still to return
    logic [28:0]           fetch_log [$];        // {is_td, addr}
    logic [28:0]           exp_fetch [$];
    ohci_desc_pkg::addr_t  wb_addr_log [$];
    ohci_desc_pkg::addr_t  exp_wb_addr [$];
    ohci_desc_pkg::dword_t wb_headp_log [$];
    ohci_desc_pkg::dword_t exp_wb_headp [$];
    logic                  stall_en;             // random ready stalls and DMA gaps

    ohci_desc_unpacker_top ohci_desc_unpacker_top_i (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .start_i        (start_i),
        .cbsr_i         (cbsr_i),
        .control_head_i (control_head_i),
        .bulk_head_i    (bulk_head_i),
        .dma_data_i     (dma_data_i),
        .dma_valid_i    (dma_valid_i),
        .dma_ready_o    (dma_ready_o),
        .fetch_valid_o  (fetch_valid_o),
        .fetch_addr_o   (fetch_addr_o),
        .fetch_is_td_o  (fetch_is_td_o),
        .fetch_ready_i  (fetch_ready_i),
        .wb_valid_o     (wb_valid_o),
        .wb_addr_o      (wb_addr_o),
        .wb_headp_o     (wb_headp_o),
        .wb_ready_i     (wb_ready_i),
        .done_o         (done_o),
        .busy_o         (busy_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i; // 40 ns period
    end

    // memory side of the DMA, readies and word stream change on falling edges only
    initial begin
        fetch_ready_i = 1'b1;
        wb_ready_i    = 1'b1;
        dma_valid_i   = 1'b0;
        dma_data_i    = '0;
        forever begin
            @(negedge clk_i);
            fetch_ready_i = !stall_en || (($urandom % 4) != 0);
            wb_ready_i    = !stall_en || (($urandom % 3) != 0);
            if (!rst_i && (dma_q.size() != 0) && (!stall_en || (($urandom % 3) != 0))) begin
                dma_valid_i = 1'b1;
                dma_data_i  = dma_q[0];
            end else begin
                dma_valid_i = 1'b0; // gap
                dma_data_i  = '0;
            end
        end
    end

    // unwritten words echo their own address
    function automatic ohci_desc_pkg::dword_t mem_word(input ohci_desc_pkg::addr_t a,
                                                       input int w);
        logic [29:0] key;
        key = {a, 2'(w)};
        if (mem.exists(key)) begin
            return mem[key];
        end
        return {2'b10, key};
    endfunction

    // handshake monitor, values are settled since the falling edge
    always @(posedge clk_i) begin
        if (rst_i) begin
            dma_q.delete();
        end else begin
            if (dma_valid_i && dma_ready_o) begin
                void'(dma_q.pop_front());
            end
            if (fetch_valid_o && fetch_ready_i) begin
                fetch_log.push_back({fetch_is_td_o, fetch_addr_o});
                for (int i = 0; i < 4; i++) begin
                    dma_q.push_back(mem_word(fetch_addr_o, i));
                end
            end
            if (wb_valid_o && wb_ready_i) begin
                wb_addr_log.push_back(wb_addr_o);
                wb_headp_log.push_back(wb_headp_o);
            end
        end
    end

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic apply_reset();
        @(negedge clk_i);
        rst_i = 1'b1;
        repeat (5) @(negedge clk_i);
        rst_i = 1'b0;
    endtask

    task automatic put_ed(input ohci_desc_pkg::addr_t ed, input logic skip,
                          input ohci_desc_pkg::addr_t tailp, input ohci_desc_pkg::dword_t headp,
                          input ohci_desc_pkg::addr_t next_ed);
        mem[{ed, 2'd0}] = {16'h0040, 1'b0, skip, 14'h0081}; // mps 64, skip in bit 14
        mem[{ed, 2'd1}] = {tailp, 4'h0};
        mem[{ed, 2'd2}] = headp;                            // halt bit 0, carry bit 1
        mem[{ed, 2'd3}] = {next_ed, 4'h0};
    endtask

    task automatic put_td(input ohci_desc_pkg::addr_t td, input ohci_desc_pkg::addr_t next_td);
        mem[{td, 2'd0}] = 32'hf200_0000;
        mem[{td, 2'd1}] = 32'h0001_0000;    // buffer start
        mem[{td, 2'd2}] = {next_td, 4'h0};
        mem[{td, 2'd3}] = 32'h0001_003f;
    endtask

    // ED with one pending TD, TD links straight to TailP
    task automatic put_pending(input ohci_desc_pkg::addr_t ed, input ohci_desc_pkg::addr_t next_ed,
                               input ohci_desc_pkg::addr_t td, input ohci_desc_pkg::addr_t tail,
                               input logic [3:0] low);
        put_ed(ed, 1'b0, tail, {td, low}, next_ed);
        put_td(td, tail);
    endtask

    task automatic expect_fetch(input logic is_td, input ohci_desc_pkg::addr_t a);
        exp_fetch.push_back({is_td, a});
    endtask

    // ED fetch, TD fetch, then HeadP moves to NextTD with flags kept
    task automatic expect_served(input ohci_desc_pkg::addr_t ed, input ohci_desc_pkg::addr_t td,
                                 input ohci_desc_pkg::addr_t tail, input logic [3:0] low);
        expect_fetch(1'b0, ed);
        expect_fetch(1'b1, td);
        exp_wb_addr.push_back(ed);
        exp_wb_headp.push_back({tail, low});
    endtask

    task automatic compare_logs();
        check_value("fetch handshakes", 64'(fetch_log.size()), 64'(exp_fetch.size()));
        foreach (exp_fetch[i]) begin
            check_value("{fetch_is_td_o, fetch_addr_o}", 64'(fetch_log[i]), 64'(exp_fetch[i]));
        end
        check_value("wb handshakes", 64'(wb_addr_log.size()), 64'(exp_wb_addr.size()));
        foreach (exp_wb_addr[i]) begin
            check_value("wb_addr_o", 64'(wb_addr_log[i]), 64'(exp_wb_addr[i]));
            check_value("wb_headp_o", 64'(wb_headp_log[i]), 64'(exp_wb_headp[i]));
        end
        exp_fetch.delete();
        exp_wb_addr.delete();
        exp_wb_headp.delete();
    endtask

    task automatic start_walk(input ohci_desc_pkg::addr_t ctrl, input ohci_desc_pkg::addr_t bulk,
                              input ohci_desc_pkg::cbsr_t cbsr);
        fetch_log.delete();
        wb_addr_log.delete();
        wb_headp_log.delete();
        control_head_i = ctrl;
        bulk_head_i    = bulk;
        cbsr_i         = cbsr;
        start_i        = 1'b1;
        @(negedge clk_i);
        start_i = 1'b0;
        check_value("busy_o", 64'(busy_o), 64'd1);
    endtask

    task automatic run_walk(input ohci_desc_pkg::addr_t ctrl, input ohci_desc_pkg::addr_t bulk,
                            input ohci_desc_pkg::cbsr_t cbsr);
        int n;
        start_walk(ctrl, bulk, cbsr);
        n = 0;
        while (!done_o) begin
            if (n == 3000) begin
                $display("timeout: done_o did not rise within 3000 cycles");
                abort_run();
            end
            @(negedge clk_i);
            n++;
        end
        @(negedge clk_i);
        check_value("done_o", 64'(done_o), 64'd0); // single cycle pulse
        check_value("busy_o", 64'(busy_o), 64'd0);
    endtask

    task automatic test_single_td();
        put_ed(28'h010, 1'b0, 28'h0f0, {28'h020, 4'h2}, 28'h0); // carry set
        put_td(28'h020, 28'h0f0);
        run_walk(28'h010, 28'h0, 2'd0);
        expect_served(28'h010, 28'h020, 28'h0f0, 4'h2);
        compare_logs();
    endtask

    task automatic test_pass_over();
        put_ed(28'h100, 1'b1, 28'h1f0, {28'h180, 4'h0}, 28'h110); // skip
        put_ed(28'h110, 1'b0, 28'h1f1, {28'h190, 4'h1}, 28'h120); // halted
        put_ed(28'h120, 1'b0, 28'h1f2, {28'h1f2, 4'h2}, 28'h0);   // HeadP == TailP
        put_ed(28'h130, 1'b1, 28'h1f3, {28'h1a0, 4'h0}, 28'h0);
        run_walk(28'h100, 28'h130, 2'd0);
        expect_fetch(1'b0, 28'h100);
        expect_fetch(1'b0, 28'h110);
        expect_fetch(1'b0, 28'h120);
        expect_fetch(1'b0, 28'h130);
        compare_logs();
    endtask

    // ratio 2:1, three control EDs against two bulk EDs
    task automatic test_ratio_order(input logic stall);
        stall_en = stall;
        put_pending(28'h300, 28'h310, 28'h380, 28'h3f0, 4'h2);
        put_pending(28'h310, 28'h320, 28'h390, 28'h3f1, 4'h0);
        put_pending(28'h320, 28'h0,   28'h3a0, 28'h3f2, 4'h2);
        put_pending(28'h400, 28'h410, 28'h480, 28'h4f0, 4'h0);
        put_pending(28'h410, 28'h0,   28'h490, 28'h4f1, 4'h2);
        run_walk(28'h300, 28'h400, 2'd1);
        expect_served(28'h300, 28'h380, 28'h3f0, 4'h2); // control
        expect_served(28'h310, 28'h390, 28'h3f1, 4'h0); // control
        expect_served(28'h400, 28'h480, 28'h4f0, 4'h0); // bulk
        expect_served(28'h320, 28'h3a0, 28'h3f2, 4'h2); // control, list ends
        expect_served(28'h410, 28'h490, 28'h4f1, 4'h2); // bulk
        compare_logs();
        stall_en = 1'b0;
    endtask

    task automatic test_stray_and_reset();
        int n;
        @(posedge clk_i);
        for (int i = 0; i < 6; i++) begin
            dma_q.push_back(32'hdead_be00 + i); // no fetch outstanding
        end
        @(negedge clk_i);
        n = 0;
        while (dma_q.size() != 0) begin
            if (n == 100) begin
                $display("timeout: stray DMA words were not accepted");
                abort_run();
            end
            @(negedge clk_i);
            n++;
        end
        check_value("busy_o", 64'(busy_o), 64'd0);
        test_single_td(); // strays must not leak into the next descriptor
        stall_en = 1'b1;
        start_walk(28'h300, 28'h400, 2'd1);
        n = 0;
        while (wb_addr_log.size() == 0) begin
            if (n == 1000) begin
                $display("timeout: no writeback before the mid-walk reset");
                abort_run();
            end
            @(negedge clk_i);
            n++;
        end
        apply_reset();
        check_value("fetch_valid_o", 64'(fetch_valid_o), 64'd0);
        check_value("wb_valid_o", 64'(wb_valid_o), 64'd0);
        check_value("busy_o", 64'(busy_o), 64'd0);
        check_value("dma_ready_o", 64'(dma_ready_o), 64'd1); // flushing again
        test_ratio_order(1'b1);
    endtask

    initial begin
        void'($urandom(32'h7c1b_ad62));
        rst_i          = 1'b1;
        start_i        = 1'b0;
        cbsr_i         = '0;
        control_head_i = '0;
        bulk_head_i    = '0;
        stall_en       = 1'b0;
        apply_reset();
        test_single_td();
        test_pass_over();
        test_ratio_order(1'b0);
        test_ratio_order(1'b1);
        test_stray_and_reset();
        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
design/ohci_desc_pkg.sv
design/ohci_fetch_tracker.sv
design/ohci_cb_ratio_counter.sv
design/ohci_list_walker.sv
design/ohci_request_port.sv
design/ohci_desc_unpacker_top.sv
verification/ohci_desc_unpacker_sva.sv
verification/tb_ohci_desc_unpacker.sv

//--- Makefile
# Verilator build and run of the descriptor unpacker testbench
VERILATOR = verilator
VFLAGS    = --binary --assert -j 0
TOP       = tb_ohci_desc_unpacker
FILELIST  = sources.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then exit 1; fi
	@if grep -q "%Error" $(LOG); then echo "simulation reported an error"; exit 1; fi
	@grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
